/* design/ss_pkg.sv */
// shared types and constants for the dual-issue LC4 ALU datapath
// widths, opcodes, decoded-slot and retire records, write forwarding helper
package ss_pkg;

    // datapath and register file geometry
    localparam int WORD_W  = 16;
    localparam int REG_CNT = 8;
    localparam int LANES   = 2;

    typedef logic [WORD_W-1:0]          word_t;
    typedef logic [$clog2(REG_CNT)-1:0] reg_sel_t;
    // one-hot condition code, n z p from msb to lsb
    typedef logic [2:0]                 nzp_t;
    typedef logic [3:0]                 opcode_t;

    localparam word_t RESET_PC = 16'h8200;

    // top nibble of the instruction word
    localparam opcode_t OPC_NOP   = 4'b0000;
    localparam opcode_t OPC_ADD   = 4'b0001;
    localparam opcode_t OPC_LOGIC = 4'b0101;
    localparam opcode_t OPC_CONST = 4'b1001;

    localparam nzp_t NZP_NEG  = 3'b100;
    localparam nzp_t NZP_ZERO = 3'b010;
    localparam nzp_t NZP_POS  = 3'b001;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_MUL, ALU_SUB, ALU_ADDI,
        ALU_AND, ALU_NOT, ALU_OR, ALU_XOR, ALU_ANDI,
        ALU_CONST
    } alu_op_e;

    // retire stall code, matches the reference test interface
    typedef enum logic [1:0] {
        STALL_NONE = 2'd0,
        STALL_PIPE = 2'd1
    } stall_e;

    // one decoded instruction in D or X
    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    insn;
        reg_sel_t rs;
        reg_sel_t rt;
        reg_sel_t rd;
        logic     rs_re;
        logic     rt_re;
        logic     rf_we;
        logic     nzp_we;
        alu_op_e  op;
        stall_e   stall;
    } slot_t;

    // W-stage result, also the per-lane retire report
    typedef struct packed {
        logic     valid;
        stall_e   stall;
        word_t    pc;
        word_t    insn;
        logic     rf_we;
        reg_sel_t wsel;
        word_t    data;
        logic     nzp_we;
        nzp_t     nzp;
    } retire_t;

    // register write as seen by the bypass and the register file
    typedef struct packed {
        logic     we;
        reg_sel_t sel;
        word_t    data;
    } wb_t;

    // newest matching write wins, higher lane index is younger
    function automatic word_t wb_forward(input reg_sel_t sel, input word_t base,
                                         input wb_t [LANES-1:0] wb);
        word_t val;
        val = base;
        for (int i = 0; i < LANES; i++) begin
            if (wb[i].we && (wb[i].sel == sel)) begin
                val = wb[i].data;
            end
        end
        return val;
    endfunction

endpackage

/* design/ss_decoder.sv */
// LC4 decoder for the ALU subset
// maps one instruction word to selects, enables and an ALU operation
`timescale 1ns/1ps

module ss_decoder import ss_pkg::*; (
    input  word_t i_insn,
    input  word_t i_pc,
    output slot_t o_slot
);

    opcode_t opcode;
    // set when the word is one of the kept operations
    logic    known;
    // register form reads rt as well as rs
    logic    uses_rt;

    assign opcode = i_insn[15:12];

    always_comb begin
        o_slot       = '0;
        o_slot.valid = 1'b1;
        o_slot.pc    = i_pc;
        o_slot.insn  = i_insn;
        o_slot.rd    = i_insn[11:9];
        o_slot.rs    = i_insn[8:6];
        o_slot.rt    = i_insn[2:0];
        o_slot.op    = ALU_ADD;
        o_slot.stall = STALL_NONE;
        known        = 1'b1;
        uses_rt      = 1'b0;

        case (opcode)
            OPC_ADD: begin
                // bit 5 selects the imm5 form
                if (i_insn[5]) begin
                    o_slot.op = ALU_ADDI;
                end else begin
                    uses_rt = 1'b1;
                    case (i_insn[4:3])
                        2'b00:   o_slot.op = ALU_ADD;
                        2'b01:   o_slot.op = ALU_MUL;
                        2'b10:   o_slot.op = ALU_SUB;
                        // DIV is not in this datapath
                        default: known = 1'b0;
                    endcase
                end
                o_slot.rs_re = known;
                o_slot.rt_re = known && uses_rt;
            end
            OPC_LOGIC: begin
                if (i_insn[5]) begin
                    o_slot.op = ALU_ANDI;
                end else begin
                    case (i_insn[4:3])
                        2'b00:   o_slot.op = ALU_AND;
                        2'b01:   o_slot.op = ALU_NOT;
                        2'b10:   o_slot.op = ALU_OR;
                        default: o_slot.op = ALU_XOR;
                    endcase
                    // NOT has a single source
                    uses_rt = (i_insn[4:3] != 2'b01);
                end
                o_slot.rs_re = 1'b1;
                o_slot.rt_re = uses_rt;
            end
            // imm9 only, no register reads
            OPC_CONST: o_slot.op = ALU_CONST;
            OPC_NOP:   known = 1'b0;
            // anything else retires as a NOP
            default:   known = 1'b0;
        endcase

        o_slot.rf_we  = known;
        o_slot.nzp_we = known;
    end

endmodule

/* design/ss_issue.sv */
// issue unit with the fetch PC, in-pair dependence check and D-stage slot registers
// a dependent B is dropped and fetched again as the next A
`timescale 1ns/1ps

module ss_issue import ss_pkg::*; (
    input  logic                gwe,
    input  logic                i_arst_n,
    input  word_t               i_insn_a,
    input  word_t               i_insn_b,
    output word_t               o_cur_pc,
    output slot_t [LANES-1:0]   o_slot
);

    word_t pc_q;
    word_t pc_b;
    word_t pc_next;
    slot_t dec_a;
    slot_t dec_b;
    slot_t slot_b_next;
    logic  b_needs_a;
    slot_t [LANES-1:0] slot_q;

    // B sits one word above A
    assign pc_b = pc_q + 16'd1;

    ss_decoder u_dec_a (
        .i_insn (i_insn_a),
        .i_pc   (pc_q),
        .o_slot (dec_a)
    );

    ss_decoder u_dec_b (
        .i_insn (i_insn_b),
        .i_pc   (pc_b),
        .o_slot (dec_b)
    );

    // B reads a register that A writes in the same pair
    assign b_needs_a = dec_a.rf_we &&
                       ((dec_b.rs_re && (dec_b.rs == dec_a.rd)) ||
                        (dec_b.rt_re && (dec_b.rt == dec_a.rd)));

    always_comb begin
        slot_b_next = dec_b;
        if (b_needs_a) begin
            // keep pc and insn for the retire report, kill all effects
            slot_b_next.valid  = 1'b0;
            slot_b_next.rf_we  = 1'b0;
            slot_b_next.nzp_we = 1'b0;
            slot_b_next.stall  = STALL_PIPE;
        end
    end

    // split pair advances by one so B comes back in slot A
    assign pc_next = b_needs_a ? pc_b : (pc_q + 16'd2);

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc_q   <= RESET_PC;
            slot_q <= '0;
        end else begin
            pc_q      <= pc_next;
            slot_q[0] <= dec_a;
            slot_q[1] <= slot_b_next;
        end
    end

    assign o_cur_pc = pc_q;
    assign o_slot   = slot_q;

endmodule

/* design/ss_lane.sv */
// one execution lane, X and W stages
// W-result bypass into X, ALU, NZP and the retire record
`timescale 1ns/1ps

module ss_lane import ss_pkg::*; (
    input  logic              gwe,
    input  logic              i_arst_n,
    input  slot_t             i_slot,
    input  word_t             i_rs_data,
    input  word_t             i_rt_data,
    input  wb_t [LANES-1:0]   i_wb,
    output retire_t           o_retire
);

    slot_t   x_slot_q;
    word_t   x_rs_q;
    word_t   x_rt_q;
    word_t   rs_val;
    word_t   rt_val;
    word_t   imm5;
    word_t   imm9;
    word_t   alu_res;
    nzp_t    alu_nzp;
    retire_t w_q;

    // X stage control
    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            x_slot_q <= '0;
        end else begin
            x_slot_q <= i_slot;
        end
    end

    // operands read from the register file in D
    always_ff @(posedge gwe) begin
        x_rs_q <= i_rs_data;
        x_rt_q <= i_rt_data;
    end

    // older pair now in W overrides the D-stage read, lane B first
    assign rs_val = wb_forward(x_slot_q.rs, x_rs_q, i_wb);
    assign rt_val = wb_forward(x_slot_q.rt, x_rt_q, i_wb);

    // sign-extended immediates
    assign imm5 = {{(WORD_W-5){x_slot_q.insn[4]}}, x_slot_q.insn[4:0]};
    assign imm9 = {{(WORD_W-9){x_slot_q.insn[8]}}, x_slot_q.insn[8:0]};

    always_comb begin
        case (x_slot_q.op)
            ALU_ADD:   alu_res = rs_val + rt_val;
            // low half of the product only
            ALU_MUL:   alu_res = rs_val * rt_val;
            ALU_SUB:   alu_res = rs_val - rt_val;
            ALU_ADDI:  alu_res = rs_val + imm5;
            ALU_AND:   alu_res = rs_val & rt_val;
            ALU_NOT:   alu_res = ~rs_val;
            ALU_OR:    alu_res = rs_val | rt_val;
            ALU_XOR:   alu_res = rs_val ^ rt_val;
            ALU_ANDI:  alu_res = rs_val & imm5;
            ALU_CONST: alu_res = imm9;
            default:   alu_res = '0;
        endcase
    end

    // condition code of the signed result
    always_comb begin
        if ($signed(alu_res) > 0) begin
            alu_nzp = NZP_POS;
        end else if (alu_res == '0) begin
            alu_nzp = NZP_ZERO;
        end else begin
            alu_nzp = NZP_NEG;
        end
    end

    // W stage record
    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            w_q <= '0;
        end else begin
            w_q.valid  <= x_slot_q.valid;
            w_q.stall  <= x_slot_q.stall;
            w_q.pc     <= x_slot_q.pc;
            w_q.insn   <= x_slot_q.insn;
            w_q.rf_we  <= x_slot_q.rf_we;
            w_q.wsel   <= x_slot_q.rd;
            w_q.data   <= alu_res;
            w_q.nzp_we <= x_slot_q.nzp_we;
            w_q.nzp    <= alu_nzp;
        end
    end

    assign o_retire = w_q;

endmodule

/* design/ss_regfile.sv */
// register file, eight words, one rs and one rt port per lane
// two write ports with lane B winning, writes pass through to same-cycle reads
`timescale 1ns/1ps

module ss_regfile import ss_pkg::*; (
    input  logic                  gwe,
    input  logic                  i_arst_n,
    input  reg_sel_t [LANES-1:0]  i_rs_sel,
    input  reg_sel_t [LANES-1:0]  i_rt_sel,
    output word_t [LANES-1:0]     o_rs_data,
    output word_t [LANES-1:0]     o_rt_data,
    input  wb_t [LANES-1:0]       i_wb
);

    word_t regs_q [REG_CNT];

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int r = 0; r < REG_CNT; r++) begin
                regs_q[r] <= '0;
            end
        end else begin
            // later port assigned last, so B takes a shared address
            for (int i = 0; i < LANES; i++) begin
                if (i_wb[i].we) begin
                    regs_q[i_wb[i].sel] <= i_wb[i].data;
                end
            end
        end
    end

    // read ports with write-through
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            o_rs_data[i] = wb_forward(i_rs_sel[i], regs_q[i_rs_sel[i]], i_wb);
            o_rt_data[i] = wb_forward(i_rt_sel[i], regs_q[i_rt_sel[i]], i_wb);
        end
    end

endmodule

/* design/ss_writeback.sv */
// writeback unit, turns the two W records into register writes
// drops A's write when B targets the same register in that cycle
`timescale 1ns/1ps

module ss_writeback import ss_pkg::*; (
    input  retire_t [LANES-1:0]  i_retire,
    output wb_t [LANES-1:0]      o_wb
);

    wb_t [LANES-1:0] lane_wb;
    logic            same_dest;

    // raw write per lane, killed slots never write
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            lane_wb[i].we   = i_retire[i].valid && i_retire[i].rf_we;
            lane_wb[i].sel  = i_retire[i].wsel;
            lane_wb[i].data = i_retire[i].data;
        end
    end

    // B is the younger instruction of the pair
    assign same_dest = lane_wb[0].we && lane_wb[1].we &&
                       (lane_wb[0].sel == lane_wb[1].sel);

    always_comb begin
        o_wb = lane_wb;
        if (same_dest) begin
            o_wb[0].we = 1'b0;
        end
    end

endmodule

/* design/ss_core.sv */
// two-way in-order LC4 ALU core
// issue feeds two lanes, writeback drains them into the register file
`timescale 1ns/1ps

module ss_core import ss_pkg::*; (
    input  logic    gwe,
    input  logic    i_arst_n,
    input  word_t   i_insn_a,
    input  word_t   i_insn_b,
    output word_t   o_cur_pc,
    output retire_t o_retire_a,
    output retire_t o_retire_b
);

    slot_t    [LANES-1:0] slot;
    reg_sel_t [LANES-1:0] rs_sel;
    reg_sel_t [LANES-1:0] rt_sel;
    word_t    [LANES-1:0] rs_data;
    word_t    [LANES-1:0] rt_data;
    retire_t  [LANES-1:0] retire;
    wb_t      [LANES-1:0] wb;

    ss_issue u_issue (
        .gwe      (gwe),
        .i_arst_n (i_arst_n),
        .i_insn_a (i_insn_a),
        .i_insn_b (i_insn_b),
        .o_cur_pc (o_cur_pc),
        .o_slot   (slot)
    );

    // lane 0 is A, lane 1 is B
    for (genvar g = 0; g < LANES; g++) begin : g_lane
        // D-stage slot drives its own read ports
        assign rs_sel[g] = slot[g].rs;
        assign rt_sel[g] = slot[g].rt;

        ss_lane u_lane (
            .gwe       (gwe),
            .i_arst_n  (i_arst_n),
            .i_slot    (slot[g]),
            .i_rs_data (rs_data[g]),
            .i_rt_data (rt_data[g]),
            .i_wb      (wb),
            .o_retire  (retire[g])
        );
    end

    ss_writeback u_writeback (
        .i_retire (retire),
        .o_wb     (wb)
    );

    ss_regfile u_regfile (
        .gwe       (gwe),
        .i_arst_n  (i_arst_n),
        .i_rs_sel  (rs_sel),
        .i_rt_sel  (rt_sel),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data),
        .i_wb      (wb)
    );

    assign o_retire_a = retire[0];
    assign o_retire_b = retire[1];

endmodule

/* verification/ss_core_programs.svh */
// test program table for the dual-issue LC4 core testbench
// programs stored back to back, with expected R0 to R7 after each one

localparam int NUM_TESTS = 5;
localparam int ROM_WORDS = 41;

string test_name [NUM_TESTS] = '{"independent pairs", "dependent pair split",
                                 "cross-cycle bypass", "same-register writes",
                                 "nop and unsupported"};

// first word and length of each program in the rom
localparam int TEST_START [NUM_TESTS] = '{0, 6, 11, 23, 33};
localparam int TEST_LEN   [NUM_TESTS] = '{6, 5, 12, 10, 8};

localparam word_t PROG_ROM [ROM_WORDS] = '{
    // const x4, then add and sub with no pair dependence
    16'h9005, 16'h93FD, 16'h9464, 16'h9600, 16'h1801, 16'h1A90,
    // every pair splits, const add mul not xor chain
    16'h9207, 16'h1441, 16'h168A, 16'h58C8, 16'h5B19,
    // chains across adjacent pairs and pairs two apart
    16'h93EC, 16'h940C, 16'h1642, 16'h1891, 16'h5A52, 16'h5CC4,
    16'h1EFF, 16'h512D, 16'h134E, 16'h55D8, 16'h1651, 16'h18A0,
    // both lanes write r1, then r6
    16'h9205, 16'h9209, 16'h1441, 16'h9601, 16'h1843, 16'h1B63,
    16'h9DFF, 16'h5C48, 16'h1F86, 16'h11A0,
    // nop, div, trap, load and shift words write nothing
    16'h9203, 16'h0000, 16'h1459, 16'h1641, 16'hF0FF, 16'h6283,
    16'h1881, 16'hA241
};

// final register values, R0 first
localparam word_t EXP_REGS [NUM_TESTS*REG_CNT] = '{
    16'h0005, 16'hFFFD, 16'h0064, 16'h0000, 16'h0002, 16'h005F, 16'h0000, 16'h0000,
    16'h0000, 16'h0007, 16'h000E, 16'h00C4, 16'hFF3B, 16'hFF3C, 16'h0000, 16'h0000,
    16'h0000, 16'hFD80, 16'hFFF7, 16'h0000, 16'hFFF7, 16'hFFEC, 16'h0020, 16'hFFF7,
    16'hFFF6, 16'h0009, 16'h0012, 16'h0001, 16'h000A, 16'h0003, 16'hFFF6, 16'hFFEC,
    16'h0000, 16'h0003, 16'h0000, 16'h0006, 16'h0003, 16'h0000, 16'h0000, 16'h0000
};

/* verification/ss_core_tb.sv */
// testbench for the dual-issue LC4 ALU core
// runs each table program against a sequential model, then reads back all registers
`timescale 1ns/1ps

module ss_core_tb import ss_pkg::*; ();

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 8;
    localparam int MEM_DEPTH    = 64;
    // fetch to W in three edges
    localparam int PIPE_LATENCY = 3;

    `include "ss_core_programs.svh"

    logic    gwe;
    logic    i_arst_n;
    word_t   i_insn_a;
    word_t   i_insn_b;
    word_t   o_cur_pc;
    retire_t o_retire_a;
    retire_t o_retire_b;

    word_t   imem [MEM_DEPTH];
    // architectural registers of the sequential model
    word_t   model_rf [REG_CNT];
    retire_t exp_q [$];
    int      errors;
    int      checks;

    ss_core dut0 (
        .gwe        (gwe),
        .i_arst_n   (i_arst_n),
        .i_insn_a   (i_insn_a),
        .i_insn_b   (i_insn_b),
        .o_cur_pc   (o_cur_pc),
        .o_retire_a (o_retire_a),
        .o_retire_b (o_retire_b)
    );

    initial begin
        gwe = 1'b0;
        forever begin
            #(CLK_PERIOD / 2);
            gwe = ~gwe;
        end
    end

    // words past the program end read as NOP
    function automatic word_t fetch_word(input word_t pc);
        int idx;
        idx = int'(pc - RESET_PC);
        if (idx < MEM_DEPTH) begin
            return imem[idx];
        end
        return 16'h0000;
    endfunction

    // instruction memory returns the pair at pc and pc+1
    initial begin
        i_insn_a = '0;
        i_insn_b = '0;
        forever begin
            @(posedge gwe);
            #1;
            i_insn_a = fetch_word(o_cur_pc);
            i_insn_b = fetch_word(o_cur_pc + 16'd1);
        end
    end

    // DIV is the only ADD-group form without a write
    function automatic logic insn_writes(input word_t insn);
        case (insn[15:12])
            OPC_ADD:              return !(!insn[5] && insn[4:3] == 2'b11);
            OPC_LOGIC, OPC_CONST: return 1'b1;
            default:              return 1'b0;
        endcase
    endfunction

    // B needs A when one of B's live sources is A's destination
    function automatic logic pair_splits(input word_t ia, input word_t ib);
        logic rs_used;
        logic rt_used;
        rs_used = 1'b0;
        rt_used = 1'b0;
        if (ib[15:12] == OPC_ADD) begin
            rs_used = insn_writes(ib);
            rt_used = rs_used && !ib[5];
        end else if (ib[15:12] == OPC_LOGIC) begin
            rs_used = 1'b1;
            rt_used = !ib[5] && (ib[4:3] != 2'b01);
        end
        return insn_writes(ia) && ((rs_used && ib[8:6] == ia[11:9]) ||
                                   (rt_used && ib[2:0] == ia[11:9]));
    endfunction

    // executes one instruction on model_rf, returns its retire record
    function automatic retire_t model_exec(input word_t pc, input word_t insn);
        retire_t r;
        word_t   a;
        word_t   b;
        word_t   imm5;
        word_t   res;
        a    = model_rf[insn[8:6]];
        b    = model_rf[insn[2:0]];
        imm5 = {{(WORD_W-5){insn[4]}}, insn[4:0]};
        res  = '0;
        case (insn[15:12])
            OPC_ADD: begin
                case ({insn[5], insn[4:3]})
                    3'b000:  res = a + b;
                    3'b001:  res = a * b;
                    3'b010:  res = a - b;
                    3'b011:  res = '0;
                    default: res = a + imm5;
                endcase
            end
            OPC_LOGIC: begin
                case ({insn[5], insn[4:3]})
                    3'b000:  res = a & b;
                    3'b001:  res = ~a;
                    3'b010:  res = a | b;
                    3'b011:  res = a ^ b;
                    default: res = a & imm5;
                endcase
            end
            OPC_CONST: res = {{(WORD_W-9){insn[8]}}, insn[8:0]};
            default:   res = '0;
        endcase
        r        = '0;
        r.valid  = 1'b1;
        r.stall  = STALL_NONE;
        r.pc     = pc;
        r.insn   = insn;
        r.rf_we  = insn_writes(insn);
        r.nzp_we = r.rf_we;
        r.wsel   = insn[11:9];
        r.data   = res;
        // sign bit first, then zero
        r.nzp    = res[WORD_W-1] ? NZP_NEG : ((res == '0) ? NZP_ZERO : NZP_POS);
        if (r.rf_we) begin
            model_rf[r.wsel] = res;
        end
        return r;
    endfunction

    task automatic report_error(input string msg);
        errors++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_nzp(input nzp_t got, input nzp_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_retire(input retire_t got, input retire_t exp, input string what);
        checks++;
        if (got.valid !== exp.valid || got.stall !== exp.stall) begin
            errors++;
            $display("Mismatch at %0t ns: %s valid %b stall %0d, expected valid %b stall %0d",
                     $time, what, got.valid, got.stall, exp.valid, exp.stall);
        end
        check_word(got.pc, exp.pc, {what, " pc"});
        if (exp.valid) begin
            check_word(got.insn, exp.insn, {what, " insn"});
            checks++;
            if (got.rf_we !== exp.rf_we || got.nzp_we !== exp.nzp_we ||
                (exp.rf_we && got.wsel !== exp.wsel)) begin
                errors++;
                $display("Mismatch at %0t ns: %s we %b nzp_we %b sel %0d, expected %b %b %0d",
                         $time, what, got.rf_we, got.nzp_we, got.wsel,
                         exp.rf_we, exp.nzp_we, exp.wsel);
            end
            if (exp.rf_we) begin
                check_word(got.data, exp.data, {what, " data"});
            end
            if (exp.nzp_we) begin
                check_nzp(got.nzp, exp.nzp, {what, " nzp"});
            end
        end
    endtask

    // readout words sit right after the program, one per register
    task automatic check_readout(input retire_t r, input int t);
        int idx;
        idx = int'(r.pc - RESET_PC) - TEST_LEN[t];
        if (r.valid && idx >= 0 && idx < REG_CNT) begin
            check_word(r.data, EXP_REGS[t*REG_CNT+idx], $sformatf("final R%0d", idx));
        end
    endtask

    // program, then ADD Rr, Rr, #0 for every register, then NOPs
    task automatic load_program(input int t);
        int len;
        len = TEST_LEN[t];
        exp_q.delete();
        for (int r = 0; r < REG_CNT; r++) begin
            model_rf[r] = '0;
        end
        for (int i = 0; i < MEM_DEPTH; i++) begin
            if (i < len) begin
                imem[i] = PROG_ROM[TEST_START[t] + i];
            end else if (i < len + REG_CNT) begin
                imem[i] = {OPC_ADD, reg_sel_t'(i - len), reg_sel_t'(i - len), 6'b100000};
            end else begin
                imem[i] = 16'h0000;
            end
        end
        for (int i = 0; i < len + REG_CNT; i++) begin
            exp_q.push_back(model_exec(RESET_PC + word_t'(i), imem[i]));
        end
    endtask

    task automatic run_test(input int t);
        retire_t ra;
        retire_t rb;
        retire_t e;
        retire_t k;
        int      cycles;
        int      retired;
        int      errs_before;
        cycles      = 0;
        retired     = 0;
        errs_before = errors;
        load_program(t);
        @(posedge gwe);
        #1;
        i_arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge gwe);
        #1;
        i_arst_n = 1'b1;
        check_word(o_cur_pc, RESET_PC, "pc after reset");
        if (o_retire_a.valid !== 1'b0 || o_retire_b.valid !== 1'b0) begin
            errors++;
            $display("Mismatch at %0t ns: retire valid after reset is %b%b, expected 00",
                     $time, o_retire_a.valid, o_retire_b.valid);
        end
        while (exp_q.size() > 0 && cycles < (TEST_LEN[t] + REG_CNT) * 4 + 16) begin
            @(posedge gwe);
            #2;
            cycles++;
            ra = o_retire_a;
            rb = o_retire_b;
            // first pair shows up after the fixed latency, then lane A retires every cycle
            if (ra.valid !== (cycles >= PIPE_LATENCY)) begin
                report_error($sformatf("lane A %s in cycle %0d after reset",
                                       ra.valid ? "retired too early" : "was empty",
                                       cycles));
            end
            if (!ra.valid) begin
                if (rb.valid) begin
                    report_error("lane B retired while lane A was empty");
                end
            end else begin
                e = exp_q.pop_front();
                check_retire(ra, e, "lane A");
                check_readout(ra, t);
                retired++;
                if (exp_q.size() > 0) begin
                    if (pair_splits(e.insn, exp_q[0].insn)) begin
                        // dropped B keeps its pc and comes back as the next A
                        k       = '0;
                        k.stall = STALL_PIPE;
                        k.pc    = e.pc + 16'd1;
                        check_retire(rb, k, "lane B split");
                    end else begin
                        e = exp_q.pop_front();
                        check_retire(rb, e, "lane B");
                        check_readout(rb, t);
                        retired++;
                    end
                end
            end
        end
        if (exp_q.size() > 0) begin
            report_error($sformatf("%0d instructions never retired", exp_q.size()));
        end
        $display("test %0d (%s): %0d retired, %0d errors", t, test_name[t], retired,
                 errors - errs_before);
    endtask

    initial begin
        i_arst_n = 1'b0;
        errors   = 0;
        checks   = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // about four cycles per word of every program and readout, plus resets
    initial begin : watchdog
        int limit_cycles;
        limit_cycles = (ROM_WORDS + NUM_TESTS * REG_CNT) * 4 +
                       NUM_TESTS * (RESET_CYCLES + 20) + 100;
        #(limit_cycles * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", limit_cycles);
        $display("Done: errors found");
        $finish;
    end

endmodule

/* ss_core.f */
+incdir+verification
design/ss_pkg.sv
design/ss_decoder.sv
design/ss_issue.sv
design/ss_lane.sv
design/ss_regfile.sv
design/ss_writeback.sv
design/ss_core.sv
verification/ss_core_tb.sv

/* Makefile */
# Verilator build and run of the ss_core testbench

VERILATOR ?= verilator
TOP       ?= ss_core_tb
FILELIST  ?= ss_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Done: no errors

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard design/*.sv) $(wildcard verification/*.sv) \
           $(wildcard verification/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
